//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_soc_fpga_wrapper
RTL_TOP   ?= soc_fpga_wrapper
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing
RTL_SRCS  ?= $(filter-out tb_%,$(shell cat $(FILELIST)))
PASS_MSG  ?= NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)

//--- cmd_ctrl.sv
`timescale 1ns/1ps

module cmd_ctrl (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        rx_valid_i,
   input  logic                        tx_busy_i,
   input  logic [soc_pkg::UART_W-1:0]  rx_data_i,
   output logic                        tx_start_o,
   output logic [soc_pkg::UART_W-1:0]  tx_data_o,
   output logic                        trap_o,
   wb_if.master                        wb
);

   typedef enum logic [2:0] {
      S_CMD,
      S_ADDR,
      S_DATA,
      S_BUS,
      S_RESP,
      S_TRAP
   } state_t;

   state_t                           state_q;
   logic                             we_q;
   logic [soc_pkg::MEM_ADDR_W-1:0]   adr_q;
   logic [soc_pkg::MEM_DATA_W-1:0]   dat_q;
   logic [soc_pkg::UART_W-1:0]       rsp_q;

   // bus request held for the whole classic cycle
   assign wb.cyc   = (state_q == S_BUS);
   assign wb.stb   = (state_q == S_BUS);
   assign wb.we    = we_q;
   assign wb.adr   = adr_q;
   assign wb.dat_w = dat_q;

   assign tx_start_o = (state_q == S_RESP) && !tx_busy_i;
   assign tx_data_o  = rsp_q;
   assign trap_o     = (state_q == S_TRAP);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= S_CMD;
         we_q    <= 1'b0;
      end else begin
         case (state_q)
            S_CMD: begin
               if (rx_valid_i) begin
                  if (rx_data_i == soc_pkg::CMD_WRITE) begin
                     we_q    <= 1'b1;
                     state_q <= S_ADDR;
                  end else if (rx_data_i == soc_pkg::CMD_READ) begin
                     we_q    <= 1'b0;
                     state_q <= S_ADDR;
                  end else begin
                     state_q <= S_TRAP;
                  end
               end
            end
            S_ADDR:  if (rx_valid_i) state_q <= we_q ? S_DATA : S_BUS;
            S_DATA:  if (rx_valid_i) state_q <= S_BUS;
            S_BUS:   if (wb.ack) state_q <= S_RESP;
            S_RESP:  if (!tx_busy_i) state_q <= S_CMD;
            // only reset leaves the trap
            S_TRAP:  state_q <= S_TRAP;
            default: state_q <= S_CMD;
         endcase
      end
   end

   // operands and response byte
   always_ff @(posedge clk_i) begin
      if ((state_q == S_ADDR) && rx_valid_i) adr_q <= rx_data_i[soc_pkg::MEM_ADDR_W-1:0];
      if ((state_q == S_DATA) && rx_valid_i) dat_q <= rx_data_i;
      if ((state_q == S_BUS) && wb.ack) rsp_q <= we_q ? soc_pkg::RSP_ACK : wb.dat_r;
   end

   a_stb_in_cyc : assert property (
      @(posedge clk_i) disable iff (rst_i) wb.stb |-> wb.cyc
   );

   // request must not move until the slave answers
   a_req_stable : assert property (
      @(posedge clk_i) disable iff (rst_i)
      (wb.stb && !wb.ack) |=> ($stable(wb.adr) && $stable(wb.dat_w))
   );

endmodule

//--- reset_pulse_gen.sv
`timescale 1ns/1ps

module reset_pulse_gen (
   input  logic clk_i,
   input  logic rst_i,
   output logic rst_o
);

   logic [1:0]                       sync_q;
   logic [soc_pkg::RST_CNT_W-1:0]    cnt_q;
   logic                             released;
   logic                             in_window;

   // pin release seen after two flops
   assign released = sync_q[1];

   assign in_window = (cnt_q >= soc_pkg::RST_CNT_W'(soc_pkg::RST_START)) &&
                      (cnt_q <  soc_pkg::RST_CNT_W'(soc_pkg::RST_END));

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         sync_q <= 2'b00;
         cnt_q  <= '0;
         rst_o  <= 1'b1;
      end else begin
         sync_q <= {sync_q[0], 1'b1};
         // count once past the window, then hold
         if (released && (cnt_q != soc_pkg::RST_CNT_W'(soc_pkg::RST_END))) begin
            cnt_q <= cnt_q + 1'b1;
         end
         rst_o <= in_window;
      end
   end

endmodule

//--- soc_fpga_wrapper.sv
`timescale 1ns/1ps

module soc_fpga_wrapper (
   input  logic clk_i,
   input  logic rst_i,
   input  logic uart_rxd_i,
   output logic uart_txd_o,
   output logic trap_o
);

   logic                        sys_rst;
   logic [soc_pkg::UART_W-1:0]  rx_data;
   logic                        rx_valid;
   logic [soc_pkg::UART_W-1:0]  tx_data;
   logic                        tx_start;
   logic                        tx_busy;

   wb_if wb_bus ();

   // internal reset pulse from the pin
   reset_pulse_gen reset_pulse (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .rst_o (sys_rst)
   );

   uart_rx uart_rx_i (
      .clk_i   (clk_i),
      .rst_i   (sys_rst),
      .rxd_i   (uart_rxd_i),
      .data_o  (rx_data),
      .valid_o (rx_valid)
   );

   uart_tx uart_tx_i (
      .clk_i   (clk_i),
      .rst_i   (sys_rst),
      .start_i (tx_start),
      .data_i  (tx_data),
      .txd_o   (uart_txd_o),
      .busy_o  (tx_busy)
   );

   // command decode and bus master
   cmd_ctrl cmd_ctrl_i (
      .clk_i      (clk_i),
      .rst_i      (sys_rst),
      .rx_valid_i (rx_valid),
      .tx_busy_i  (tx_busy),
      .rx_data_i  (rx_data),
      .tx_start_o (tx_start),
      .tx_data_o  (tx_data),
      .trap_o     (trap_o),
      .wb         (wb_bus.master)
   );

   sram_wb sram_i (
      .clk_i (clk_i),
      .rst_i (sys_rst),
      .wb    (wb_bus.slave)
   );

endmodule

//--- soc_pkg.sv
package soc_pkg;

   // uart framing
   localparam int CLKS_PER_BIT = 8;
   localparam int UART_W       = 8;
   localparam int FRAME_W      = UART_W + 2;
   localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);
   localparam int BIT_CNT_W    = $clog2(FRAME_W);

   // on-chip byte memory
   localparam int MEM_ADDR_W = 6;
   localparam int MEM_DATA_W = 8;
   localparam int MEM_DEPTH  = 2 ** MEM_ADDR_W;

   // internal reset pulse, in clock cycles
   localparam int RST_START    = 5;
   localparam int RST_DURATION = 10;
   localparam int RST_END      = RST_START + RST_DURATION;
   localparam int RST_CNT_W    = $clog2(RST_END + 1);

   // ascii command and response codes
   localparam logic [UART_W-1:0] CMD_WRITE = 8'h57;
   localparam logic [UART_W-1:0] CMD_READ  = 8'h52;
   localparam logic [UART_W-1:0] RSP_ACK   = 8'h4B;

endpackage

//--- sram_wb.sv
`timescale 1ns/1ps

module sram_wb (
   input  logic clk_i,
   input  logic rst_i,
   wb_if.slave  wb
);

   logic [soc_pkg::MEM_DATA_W-1:0] mem_q [soc_pkg::MEM_DEPTH];
   logic                           req;

   // new request only, so ack lasts one cycle
   assign req = wb.cyc && wb.stb && !wb.ack;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wb.ack <= 1'b0;
      end else begin
         wb.ack <= req;
      end
   end

   // contents survive reset
   always_ff @(posedge clk_i) begin
      if (req) begin
         if (wb.we) mem_q[wb.adr] <= wb.dat_w;
         wb.dat_r <= mem_q[wb.adr];
      end
   end

   a_ack_in_cycle : assert property (
      @(posedge clk_i) disable iff (rst_i) wb.ack |-> (wb.cyc && wb.stb)
   );

endmodule

//--- tb.f
soc_pkg.sv
wb_if.sv
reset_pulse_gen.sv
uart_rx.sv
uart_tx.sv
cmd_ctrl.sv
sram_wb.sv
soc_fpga_wrapper.sv
tb_soc_fpga_wrapper.sv

//--- tb_soc_fpga_wrapper.sv
`timescale 1ns/1ps

module tb_soc_fpga_wrapper;

   localparam int FRAME_CYCLES   = soc_pkg::FRAME_W * soc_pkg::CLKS_PER_BIT;
   localparam int TIMEOUT_CYCLES = 80 * 3 * FRAME_CYCLES * 2;

   logic clk;
   logic rst_i;
   logic uart_rxd_i;
   logic uart_txd_o;
   logic trap_o;

   logic [soc_pkg::MEM_DATA_W-1:0] shadow [soc_pkg::MEM_DEPTH];
   logic [soc_pkg::UART_W-1:0]     written [$];
   logic [soc_pkg::UART_W-1:0]     exp_q [$];
   logic [soc_pkg::UART_W-1:0]     act_q [$];
   string                          name_q [$];
   int                             issued = 0;
   int                             checked = 0;
   int                             rx_count = 0;
   int                             error_count = 0;
   int                             cycle_count = 0;
   integer                         seed = 58;

   soc_fpga_wrapper dut_i (
      .clk_i      (clk),
      .rst_i      (rst_i),
      .uart_rxd_i (uart_rxd_i),
      .uart_txd_o (uart_txd_o),
      .trap_o     (trap_o)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp) begin
         error_count++;
         $display("FAILED %s expected %02h actual %02h", name, exp, act);
         $display("ERRORS FOUND");
         $fatal(1);
      end
   endtask

   // expected read value, upper address bits ignored
   function automatic logic [7:0] ref_read(input logic [7:0] addr);
      return shadow[addr[soc_pkg::MEM_ADDR_W-1:0]];
   endfunction

   task automatic send_byte(input logic [soc_pkg::UART_W-1:0] b);
      logic [soc_pkg::FRAME_W-1:0] frame;
      frame = {1'b1, b, 1'b0};
      repeat (soc_pkg::FRAME_W) begin
         @(posedge clk);
         uart_rxd_i <= frame[0];
         frame = frame >> 1;
         repeat (soc_pkg::CLKS_PER_BIT - 1) @(posedge clk);
      end
   endtask

   task automatic expect_byte(input logic [7:0] b, input string name);
      exp_q.push_back(b);
      name_q.push_back(name);
      issued++;
   endtask

   task automatic wait_response();
      while (checked < issued) @(posedge clk);
   endtask

   task automatic do_write(input logic [7:0] addr, input logic [7:0] data);
      shadow[addr[soc_pkg::MEM_ADDR_W-1:0]] = data;
      written.push_back(addr);
      expect_byte(soc_pkg::RSP_ACK, "write_ack");
      send_byte(soc_pkg::CMD_WRITE);
      send_byte(addr);
      send_byte(data);
      wait_response();
   endtask

   task automatic do_read(input logic [7:0] addr, input string name);
      expect_byte(ref_read(addr), name);
      send_byte(soc_pkg::CMD_READ);
      send_byte(addr);
      wait_response();
   endtask

   // release the pin, then watch the idle outputs through the pulse window
   task automatic release_reset();
      repeat (3) @(posedge clk);
      rst_i <= 1'b0;
      repeat (40) begin
         @(negedge clk);
         check_val("reset_txd_idle", 8'h01, 8'(uart_txd_o));
         check_val("reset_trap_low", 8'h00, 8'(trap_o));
      end
      @(posedge clk);
   endtask

   // frame decoder on the transmit pin, sampled mid bit
   initial begin : tx_monitor
      logic [soc_pkg::UART_W-1:0] data;
      data = '0;
      forever begin
         @(negedge clk);
         if (!rst_i && uart_txd_o === 1'b0) begin
            repeat (soc_pkg::CLKS_PER_BIT / 2) @(negedge clk);
            check_val("tx_start_bit", 8'h00, 8'(uart_txd_o));
            repeat (soc_pkg::UART_W) begin
               repeat (soc_pkg::CLKS_PER_BIT) @(negedge clk);
               data = {uart_txd_o, data[soc_pkg::UART_W-1:1]};
            end
            repeat (soc_pkg::CLKS_PER_BIT) @(negedge clk);
            check_val("tx_stop_bit", 8'h01, 8'(uart_txd_o));
            act_q.push_back(data);
            rx_count++;
         end
      end
   end

   initial begin : compare_proc
      logic [soc_pkg::UART_W-1:0] act;
      forever begin
         @(negedge clk);
         if (act_q.size() != 0) begin
            act = act_q.pop_front();
            if (exp_q.size() == 0) begin
               $display("unexpected response byte %02h from the DUT", act);
               $display("ERRORS FOUND");
               $fatal(1);
            end else begin
               check_val(name_q.pop_front(), exp_q.pop_front(), act);
               checked++;
            end
         end
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("ERRORS FOUND");
         $fatal(1);
      end
   end

   initial begin : stimulus
      integer     rnd;
      int         idx;
      int         count_before;
      logic [7:0] addr;
      logic [7:0] data;
      rst_i      = 1'b1;
      uart_rxd_i = 1'b1;
      release_reset();

      do_write(8'h15, 8'hA5);
      do_read(8'h15, "write_read");

      // random traffic, reads only hit written addresses
      repeat (30) begin
         rnd  = $random(seed);
         addr = rnd[7:0];
         data = rnd[15:8];
         do_write(addr, data);
      end
      repeat (30) begin
         rnd = $random(seed);
         idx = (rnd & 32'h7fffffff) % written.size();
         do_read(written[idx], "random_read");
      end

      // upper two address bits are dropped
      rnd  = $random(seed);
      data = rnd[7:0];
      do_write(8'hEA, data);
      do_read(8'h2A, "addr_mask");

      send_byte(8'h5A);
      while (trap_o !== 1'b1) @(negedge clk);
      count_before = rx_count;
      send_byte(soc_pkg::CMD_READ);
      send_byte(8'h15);
      repeat (3 * FRAME_CYCLES) @(negedge clk);
      check_val("trap_no_response", 8'(count_before), 8'(rx_count));
      check_val("trap_held", 8'h01, 8'(trap_o));

      // memory keeps its contents across reset
      @(posedge clk);
      rst_i <= 1'b1;
      release_reset();
      do_read(8'h15, "read_after_reset");

      if (error_count == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

//--- uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        rxd_i,
   output logic [soc_pkg::UART_W-1:0]  data_o,
   output logic                        valid_o
);

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

   rx_state_t                        state_q;
   logic [1:0]                       sync_q;
   logic                             rxd_prev_q;
   logic [soc_pkg::BAUD_CNT_W-1:0]   baud_q;
   logic [soc_pkg::BIT_CNT_W-1:0]    bit_q;
   logic                             rxd_s;
   logic                             bit_mid;

   assign rxd_s   = sync_q[1];
   assign bit_mid = (baud_q == soc_pkg::BAUD_CNT_W'(soc_pkg::CLKS_PER_BIT - 1));

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q    <= RX_IDLE;
         sync_q     <= 2'b11;
         rxd_prev_q <= 1'b1;
         baud_q     <= '0;
         bit_q      <= '0;
         valid_o    <= 1'b0;
      end else begin
         sync_q     <= {sync_q[0], rxd_i};
         rxd_prev_q <= rxd_s;
         valid_o    <= 1'b0;
         baud_q     <= baud_q + 1'b1;
         case (state_q)
            RX_IDLE: begin
               baud_q <= '0;
               bit_q  <= '0;
               if (rxd_prev_q && !rxd_s) state_q <= RX_START;
            end
            RX_START: begin
               // middle of start bit, reject glitches
               if (baud_q == soc_pkg::BAUD_CNT_W'(soc_pkg::CLKS_PER_BIT / 2 - 1)) begin
                  baud_q  <= '0;
                  state_q <= rxd_s ? RX_IDLE : RX_DATA;
               end
            end
            RX_DATA: begin
               if (bit_mid) begin
                  bit_q <= bit_q + 1'b1;
                  if (bit_q == soc_pkg::BIT_CNT_W'(soc_pkg::UART_W - 1)) state_q <= RX_STOP;
               end
            end
            default: begin
               // framing error drops the byte
               if (bit_mid) begin
                  valid_o <= rxd_s;
                  state_q <= RX_IDLE;
               end
            end
         endcase
      end
   end

   // lsb arrives first
   always_ff @(posedge clk_i) begin
      if ((state_q == RX_DATA) && bit_mid) data_o <= {rxd_s, data_o[soc_pkg::UART_W-1:1]};
   end

endmodule

//--- uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        start_i,
   input  logic [soc_pkg::UART_W-1:0]  data_i,
   output logic                        txd_o,
   output logic                        busy_o
);

   logic [soc_pkg::FRAME_W-1:0]      shift_q;
   logic [soc_pkg::BAUD_CNT_W-1:0]   baud_q;
   logic [soc_pkg::BIT_CNT_W-1:0]    bit_q;

   // line idles high since ones are shifted in behind the frame
   assign txd_o = shift_q[0];

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         shift_q <= '1;
         busy_o  <= 1'b0;
         baud_q  <= '0;
         bit_q   <= '0;
      end else if (!busy_o) begin
         if (start_i) begin
            // stop, data, start
            shift_q <= {1'b1, data_i, 1'b0};
            busy_o  <= 1'b1;
            baud_q  <= '0;
            bit_q   <= '0;
         end
      end else if (baud_q == soc_pkg::BAUD_CNT_W'(soc_pkg::CLKS_PER_BIT - 1)) begin
         baud_q  <= '0;
         shift_q <= {1'b1, shift_q[soc_pkg::FRAME_W-1:1]};
         if (bit_q == soc_pkg::BIT_CNT_W'(soc_pkg::FRAME_W - 1)) begin
            busy_o <= 1'b0;
         end else begin
            bit_q <= bit_q + 1'b1;
         end
      end else begin
         baud_q <= baud_q + 1'b1;
      end
   end

   // a start during a frame would be lost
   a_no_start_while_busy : assert property (
      @(posedge clk_i) disable iff (rst_i) !(start_i && busy_o)
   );

endmodule

//--- wb_if.sv
`timescale 1ns/1ps

interface wb_if;

   // cycle framing, driven by the master
   logic                          cyc;
   logic                          stb;
   logic                          we;
   logic [soc_pkg::MEM_ADDR_W-1:0] adr;
   logic [soc_pkg::MEM_DATA_W-1:0] dat_w;

   // slave return path
   logic [soc_pkg::MEM_DATA_W-1:0] dat_r;
   logic                          ack;

   modport master (
      output cyc,
      output stb,
      output we,
      output adr,
      output dat_w,
      input  dat_r,
      input  ack
   );

   modport slave (
      input  cyc,
      input  stb,
      input  we,
      input  adr,
      input  dat_w,
      output dat_r,
      output ack
   );

endinterface
